/* rtl/lms_pkg.sv */
// Shared widths, sample types and board constants for the LMS frontend
// Referenced by scoped name from every RTL block
package lms_pkg;

   // Widths fixed by the LMS chip and the board
   localparam int LMS_BUS_W    = 12;                       // LMS RX/TX data bus
   localparam int ADC_PAD_BITS = 2;                        // Zero LSBs below a received word
   localparam int ADC_SAMPLE_W = LMS_BUS_W + ADC_PAD_BITS; // Sample width seen by the DSP
   localparam int LED_W        = 7;                        // Five board LEDs plus two Ethernet

   // Length of the clock-ready history behind the synthesizer reset
   localparam int CLOCK_READY_DEPTH = 6;

   typedef logic [LMS_BUS_W-1:0]    lms_bus_t;
   typedef logic [ADC_SAMPLE_W-1:0] adc_sample_t;
   typedef logic [LED_W-1:0]        led_t;

   // Set bits mark active-low board LEDs, Ethernet LEDs pass as they are
   localparam led_t LED_POLARITY_MASK = 7'b001_1111;

endpackage

/* rtl/lms_rx_capture.sv */
// Demultiplexes the two LMS receive buses into I and Q ADC samples
// The IQ select line of each bus steers the word, samples are padded to 14 bits
`timescale 1ns/1ps

module lms_rx_capture
(
   input  logic                 lms_clk,
   input  logic                 reset_i,
   input  lms_pkg::lms_bus_t    rx1_d_i,
   input  logic                 rx1_iqsel_i,
   input  lms_pkg::lms_bus_t    rx2_d_i,
   input  logic                 rx2_iqsel_i,
   output lms_pkg::adc_sample_t adc_i0_o,
   output lms_pkg::adc_sample_t adc_q0_o,
   output lms_pkg::adc_sample_t adc_i1_o,
   output lms_pkg::adc_sample_t adc_q1_o
);

   lms_pkg::adc_sample_t rx1_word;
   lms_pkg::adc_sample_t rx2_word;

   // Full-scale alignment for the DSP
   assign rx1_word = {rx1_d_i, {lms_pkg::ADC_PAD_BITS{1'b0}}};
   assign rx2_word = {rx2_d_i, {lms_pkg::ADC_PAD_BITS{1'b0}}};

   always_ff @(posedge lms_clk)
   begin
      if (reset_i)
      begin
         adc_i0_o <= '0;
         adc_q0_o <= '0;
      end
      else if (!rx1_iqsel_i)
         adc_i0_o <= rx1_word;  // I phase, Q holds
      else
         adc_q0_o <= rx1_word;  // Q phase, I holds
   end

   // Second channel, same select convention
   always_ff @(posedge lms_clk)
   begin
      if (reset_i)
      begin
         adc_i1_o <= '0;
         adc_q1_o <= '0;
      end
      else if (!rx2_iqsel_i)
         adc_i1_o <= rx2_word;
      else
         adc_q1_o <= rx2_word;
   end

endmodule

/* rtl/lms_tx_interleave.sv */
// Interleaves the I and Q samples of both channels onto the LMS transmit buses
// One shared phase register drives both IQ select outputs
`timescale 1ns/1ps

module lms_tx_interleave
(
   input  logic              lms_clk,
   input  logic              reset_i,
   input  lms_pkg::lms_bus_t dac_i0_i,
   input  lms_pkg::lms_bus_t dac_q0_i,
   input  lms_pkg::lms_bus_t dac_i1_i,
   input  lms_pkg::lms_bus_t dac_q1_i,
   output lms_pkg::lms_bus_t tx1_d_o,
   output logic              tx1_iqsel_o,
   output lms_pkg::lms_bus_t tx2_d_o,
   output logic              tx2_iqsel_o
);

   // Phase currently on the buses
   typedef enum logic
   {
      PHASE_I = 1'b0,
      PHASE_Q = 1'b1
   } tx_phase_t;

   tx_phase_t phase_q;

   always_ff @(posedge lms_clk)
   begin
      if (reset_i)
      begin
         phase_q <= PHASE_Q;  // So the first edge after reset loads I
         tx1_d_o <= '0;
         tx2_d_o <= '0;
      end
      else if (phase_q == PHASE_Q)
      begin
         phase_q <= PHASE_I;
         tx1_d_o <= dac_i0_i;
         tx2_d_o <= dac_i1_i;
      end
      else
      begin
         phase_q <= PHASE_Q;
         tx1_d_o <= dac_q0_i;
         tx2_d_o <= dac_q1_i;
      end
   end

   // Select is low with I on the bus, high with Q
   assign tx1_iqsel_o = (phase_q == PHASE_Q);
   assign tx2_iqsel_o = (phase_q == PHASE_Q);

endmodule

/* rtl/spi_fanout.sv */
// Fans one SPI master out to the DAC and both LMS chips
`timescale 1ns/1ps

module spi_fanout
(
   input  logic sclk_i,
   input  logic mosi_i,
   input  logic sen_dac_i,   // Active-low enables
   input  logic sen_lms1_i,
   input  logic sen_lms2_i,
   input  logic miso1_i,
   input  logic miso2_i,
   output logic sclk_dac_o,
   output logic mosi_dac_o,
   output logic sclk1_o,
   output logic mosi1_o,
   output logic sclk2_o,
   output logic mosi2_o,
   output logic miso_o
);

   // Unselected devices see a quiet bus
   assign sclk_dac_o = !sen_dac_i  && sclk_i;
   assign mosi_dac_o = !sen_dac_i  && mosi_i;
   assign sclk1_o    = !sen_lms1_i && sclk_i;
   assign mosi1_o    = !sen_lms1_i && mosi_i;
   assign sclk2_o    = !sen_lms2_i && sclk_i;
   assign mosi2_o    = !sen_lms2_i && mosi_i;

   // DAC has no readback, only the selected LMS answers
   assign miso_o = (!sen_lms1_i && miso1_i) || (!sen_lms2_i && miso2_i);

endmodule

/* rtl/board_status.sv */
// Synthesizer reset pulse, LMS reset release and LED drive polarity
// The pulse follows the clock-ready history, LEDs leave with one cycle of latency
`timescale 1ns/1ps

module board_status
(
   input  logic          lms_clk,
   input  logic          reset_i,
   input  logic          clock_ready_i,
   input  lms_pkg::led_t leds_i,
   output logic          pll_rst_o,
   output logic          lms1_nrst_o,
   output logic          lms2_nrst_o,
   output lms_pkg::led_t leds_o
);

   logic [lms_pkg::CLOCK_READY_DEPTH-1:0] ready_hist_q;
   logic                                  lms_nrst_q;

   always_ff @(posedge lms_clk)
   begin
      if (reset_i)
      begin
         ready_hist_q <= '0;
         lms_nrst_q   <= 1'b0;  // Hold both chips in reset
         leds_o       <= lms_pkg::LED_POLARITY_MASK;
      end
      else
      begin
         ready_hist_q <= {ready_hist_q[lms_pkg::CLOCK_READY_DEPTH-2:0], clock_ready_i};
         lms_nrst_q   <= 1'b1;
         leds_o       <= leds_i ^ lms_pkg::LED_POLARITY_MASK;  // Drive low to light
      end
   end

   // High while the clock is coming up but not yet stable for the full history.
   // A clean rise gives DEPTH-1 cycles of pulse.
   assign pll_rst_o = (|ready_hist_q) && !(&ready_hist_q);

   assign lms1_nrst_o = lms_nrst_q;
   assign lms2_nrst_o = lms_nrst_q;

endmodule

/* rtl/lms_frontend_top.sv */
// Board-level top of the dual LMS transceiver frontend
// Connects the receive, transmit, SPI and status blocks to the board pins
`timescale 1ns/1ps

module lms_frontend_top
(
   input  logic                 lms_clk,
   input  logic                 reset_i,
   // LMS receive buses
   input  lms_pkg::lms_bus_t    rx1_d_i,
   input  logic                 rx1_iqsel_i,
   input  lms_pkg::lms_bus_t    rx2_d_i,
   input  logic                 rx2_iqsel_i,
   output lms_pkg::adc_sample_t adc_i0_o,
   output lms_pkg::adc_sample_t adc_q0_o,
   output lms_pkg::adc_sample_t adc_i1_o,
   output lms_pkg::adc_sample_t adc_q1_o,
   // LMS transmit buses
   input  lms_pkg::lms_bus_t    dac_i0_i,
   input  lms_pkg::lms_bus_t    dac_q0_i,
   input  lms_pkg::lms_bus_t    dac_i1_i,
   input  lms_pkg::lms_bus_t    dac_q1_i,
   output lms_pkg::lms_bus_t    tx1_d_o,
   output logic                 tx1_iqsel_o,
   output lms_pkg::lms_bus_t    tx2_d_o,
   output logic                 tx2_iqsel_o,
   // SPI master side
   input  logic                 sclk_i,
   input  logic                 mosi_i,
   input  logic                 sen_dac_i,
   input  logic                 sen_lms1_i,
   input  logic                 sen_lms2_i,
   output logic                 miso_o,
   // SPI device pins
   output logic                 sclk_dac_o,
   output logic                 mosi_dac_o,
   output logic                 sen_dac_o,
   output logic                 sclk1_o,
   output logic                 mosi1_o,
   output logic                 sen1_o,
   input  logic                 miso1_i,
   output logic                 sclk2_o,
   output logic                 mosi2_o,
   output logic                 sen2_o,
   input  logic                 miso2_i,
   // Clocking, resets and LEDs
   input  logic                 clock_ready_i,
   output logic                 pll_rst_o,
   output logic                 lms1_nrst_o,
   output logic                 lms2_nrst_o,
   input  lms_pkg::led_t        leds_i,
   output lms_pkg::led_t        leds_o
);

   lms_rx_capture i_rx_capture
   (
      .lms_clk     (lms_clk),
      .reset_i     (reset_i),
      .rx1_d_i     (rx1_d_i),
      .rx1_iqsel_i (rx1_iqsel_i),
      .rx2_d_i     (rx2_d_i),
      .rx2_iqsel_i (rx2_iqsel_i),
      .adc_i0_o    (adc_i0_o),
      .adc_q0_o    (adc_q0_o),
      .adc_i1_o    (adc_i1_o),
      .adc_q1_o    (adc_q1_o)
   );

   lms_tx_interleave i_tx_interleave
   (
      .lms_clk     (lms_clk),
      .reset_i     (reset_i),
      .dac_i0_i    (dac_i0_i),
      .dac_q0_i    (dac_q0_i),
      .dac_i1_i    (dac_i1_i),
      .dac_q1_i    (dac_q1_i),
      .tx1_d_o     (tx1_d_o),
      .tx1_iqsel_o (tx1_iqsel_o),
      .tx2_d_o     (tx2_d_o),
      .tx2_iqsel_o (tx2_iqsel_o)
   );

   spi_fanout i_spi_fanout
   (
      .sclk_i     (sclk_i),
      .mosi_i     (mosi_i),
      .sen_dac_i  (sen_dac_i),
      .sen_lms1_i (sen_lms1_i),
      .sen_lms2_i (sen_lms2_i),
      .miso1_i    (miso1_i),
      .miso2_i    (miso2_i),
      .sclk_dac_o (sclk_dac_o),
      .mosi_dac_o (mosi_dac_o),
      .sclk1_o    (sclk1_o),
      .mosi1_o    (mosi1_o),
      .sclk2_o    (sclk2_o),
      .mosi2_o    (mosi2_o),
      .miso_o     (miso_o)
   );

   // Chip enables go to the pins unchanged
   assign sen_dac_o = sen_dac_i;
   assign sen1_o    = sen_lms1_i;
   assign sen2_o    = sen_lms2_i;

   board_status i_board_status
   (
      .lms_clk       (lms_clk),
      .reset_i       (reset_i),
      .clock_ready_i (clock_ready_i),
      .leds_i        (leds_i),
      .pll_rst_o     (pll_rst_o),
      .lms1_nrst_o   (lms1_nrst_o),
      .lms2_nrst_o   (lms2_nrst_o),
      .leds_o        (leds_o)
   );

endmodule

/* verif/tb_clock_gen.sv */
// Clock and reset source for the frontend testbench
// 20 ns lms_clk, reset held for 10 cycles and released on a falling edge
`timescale 1ns/1ps

module tb_clock_gen
(
   output logic lms_clk,
   output logic reset_o
);

   initial lms_clk = 1'b0;
   always #10 lms_clk = ~lms_clk;

   initial
   begin
      reset_o = 1'b1;
      repeat (10) @(posedge lms_clk);
      @(negedge lms_clk);
      reset_o = 1'b0;  // Away from the sampling edge
   end

endmodule

/* verif/tb_lms_frontend.sv */
// Directed testbench for the dual LMS frontend top level
// Drives on the falling edge, checks at the next falling edge or on the rising one
`timescale 1ns/1ps

module tb_lms_frontend;

   localparam int watchdog_cycles = 2000;             // Far beyond the full test sequence
   localparam lms_pkg::led_t led_mask = 7'b001_1111;  // Five active-low board LEDs

   logic lms_clk;
   logic reset_i;
   lms_pkg::lms_bus_t rx1_d_i, rx2_d_i, dac_i0_i, dac_q0_i, dac_i1_i, dac_q1_i;
   logic rx1_iqsel_i, rx2_iqsel_i;
   lms_pkg::adc_sample_t adc_i0_o, adc_q0_o, adc_i1_o, adc_q1_o;
   lms_pkg::lms_bus_t tx1_d_o, tx2_d_o;
   logic tx1_iqsel_o, tx2_iqsel_o;
   logic sclk_i, mosi_i, sen_dac_i, sen_lms1_i, sen_lms2_i, miso1_i, miso2_i;
   logic sclk_dac_o, mosi_dac_o, sen_dac_o, sclk1_o, mosi1_o, sen1_o;
   logic sclk2_o, mosi2_o, sen2_o, miso_o;
   logic clock_ready_i, pll_rst_o, lms1_nrst_o, lms2_nrst_o;
   lms_pkg::led_t leds_i, leds_o;

   integer seed = 13;
   int checks = 0;
   int errors = 0;
   int tx_edges = 0;  // Rising edges since reset release

   tb_clock_gen i_clock_gen (.lms_clk(lms_clk), .reset_o(reset_i));

   lms_frontend_top i_dut (.*);

   // Odd edge count means the I word is on the TX buses
   always @(posedge lms_clk)
   begin
      if (reset_i)
         tx_edges <= 0;
      else
         tx_edges <= tx_edges + 1;
   end

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                  $time, what, actual, expected);
      end
   endtask

   task automatic report_test_end(input string name, input int errors_before);
      $display("%s finished with %0d failed checks", name, errors - errors_before);
   endtask

   task automatic after_reset_checks();
      int errs;
      errs = errors;
      repeat (3) @(negedge lms_clk);
      check_value(32'(adc_i0_o), 0, "adc_i0 in reset");
      check_value(32'(adc_q0_o), 0, "adc_q0 in reset");
      check_value(32'(adc_i1_o), 0, "adc_i1 in reset");
      check_value(32'(adc_q1_o), 0, "adc_q1 in reset");
      check_value(32'(tx1_d_o), 0, "tx1 bus in reset");
      check_value(32'(tx2_d_o), 0, "tx2 bus in reset");
      check_value(32'({tx1_iqsel_o, tx2_iqsel_o}), 32'b11, "iqsel in reset");
      check_value(32'({lms1_nrst_o, lms2_nrst_o}), 0, "lms resets active in reset");
      check_value(32'(pll_rst_o), 0, "pll_rst in reset");
      check_value(32'(leds_o), 32'(led_mask), "leds in reset");
      wait (reset_i == 1'b0);
      @(posedge lms_clk);
      @(negedge lms_clk);
      check_value(32'({lms1_nrst_o, lms2_nrst_o}), 32'b11, "lms resets released");
      check_value(32'(pll_rst_o), 0, "pll_rst after reset");
      check_value(32'(leds_o), 32'(led_mask), "leds with zero input");
      check_value(32'(tx1_d_o), 32'(dac_i0_i), "tx1 first edge carries I");
      check_value(32'(tx2_d_o), 32'(dac_i1_i), "tx2 first edge carries I");
      check_value(32'({tx1_iqsel_o, tx2_iqsel_o}), 0, "iqsel low on first edge");
      check_value(32'(adc_i0_o), 0, "adc_i0 after reset");
      report_test_end("after_reset_checks", errs);
   endtask

   task automatic capture_rx_words();
      int errs;
      int k;
      lms_pkg::adc_sample_t exp_i0, exp_q0, exp_i1, exp_q1;
      errs = errors;
      exp_i0 = '0;  // Zero since reset, rx buses idle at zero
      exp_q0 = '0;
      exp_i1 = '0;
      exp_q1 = '0;
      @(negedge lms_clk);
      for (k = 0; k < 12; k++)
      begin
         rx1_d_i = lms_pkg::lms_bus_t'($random(seed));
         rx2_d_i = lms_pkg::lms_bus_t'($random(seed));
         rx1_iqsel_i = k[0];        // I then Q
         rx2_iqsel_i = k[1];        // Two of each in a row
         @(posedge lms_clk);
         @(negedge lms_clk);
         if (!rx1_iqsel_i) exp_i0 = {rx1_d_i, 2'b00};
         else exp_q0 = {rx1_d_i, 2'b00};
         if (!rx2_iqsel_i) exp_i1 = {rx2_d_i, 2'b00};
         else exp_q1 = {rx2_d_i, 2'b00};
         check_value(32'(adc_i0_o), 32'(exp_i0), $sformatf("adc_i0 step %0d", k));
         check_value(32'(adc_q0_o), 32'(exp_q0), $sformatf("adc_q0 step %0d", k));
         check_value(32'(adc_i1_o), 32'(exp_i1), $sformatf("adc_i1 step %0d", k));
         check_value(32'(adc_q1_o), 32'(exp_q1), $sformatf("adc_q1 step %0d", k));
      end
      report_test_end("capture_rx_words", errs);
   endtask

   task automatic interleave_tx_words();
      int errs;
      int k;
      logic i_phase;
      errs = errors;
      @(negedge lms_clk);
      dac_i0_i = lms_pkg::lms_bus_t'($random(seed));
      dac_q0_i = lms_pkg::lms_bus_t'($random(seed));
      dac_i1_i = lms_pkg::lms_bus_t'($random(seed));
      dac_q1_i = lms_pkg::lms_bus_t'($random(seed));
      for (k = 0; k < 8; k++)
      begin
         @(posedge lms_clk);
         @(negedge lms_clk);
         i_phase = (tx_edges % 2) == 1;
         check_value(32'(tx1_d_o), 32'(i_phase ? dac_i0_i : dac_q0_i),
                     $sformatf("tx1 bus edge %0d", tx_edges));
         check_value(32'(tx2_d_o), 32'(i_phase ? dac_i1_i : dac_q1_i),
                     $sformatf("tx2 bus edge %0d", tx_edges));
         check_value(32'(tx1_iqsel_o), 32'(!i_phase), "tx1 iqsel");
         check_value(32'(tx2_iqsel_o), 32'(!i_phase), "tx2 iqsel");
      end
      report_test_end("interleave_tx_words", errs);
   endtask

   task automatic walk_spi_enables();
      int errs;
      int s;
      int p;
      logic [3:0] pat;
      logic sel_dac, sel1, sel2;
      logic [6:0] exp_spi;
      errs = errors;
      @(negedge lms_clk);
      for (s = 0; s < 4; s++)        // DAC, LMS1, LMS2, then none
      begin
         for (p = 0; p < 16; p++)
         begin
            pat = 4'(p);
            sel_dac = (s == 0);
            sel1 = (s == 1);
            sel2 = (s == 2);
            sen_dac_i = !sel_dac;
            sen_lms1_i = !sel1;
            sen_lms2_i = !sel2;
            {sclk_i, mosi_i, miso1_i, miso2_i} = pat;
            exp_spi = {sel_dac & pat[3], sel_dac & pat[2], sel1 & pat[3], sel1 & pat[2],
                       sel2 & pat[3], sel2 & pat[2], (sel1 & pat[1]) | (sel2 & pat[0])};
            @(posedge lms_clk);      // Combinational outputs settled since the drive
            check_value(32'({sclk_dac_o, mosi_dac_o, sclk1_o, mosi1_o, sclk2_o, mosi2_o,
                             miso_o}), 32'(exp_spi),
                        $sformatf("spi lines, select %0d pattern %0d", s, p));
            check_value(32'({sen_dac_o, sen1_o, sen2_o}),
                        32'({sen_dac_i, sen_lms1_i, sen_lms2_i}), "enables to pins");
            @(negedge lms_clk);
         end
      end
      {sen_dac_i, sen_lms1_i, sen_lms2_i} = 3'b111;
      {sclk_i, mosi_i, miso1_i, miso2_i} = 4'b0000;
      report_test_end("walk_spi_enables", errs);
   endtask

   task automatic raise_clock_ready();
      int errs;
      int c;
      int high_cycles;
      lms_pkg::led_t drive;
      errs = errors;
      high_cycles = 0;
      @(negedge lms_clk);
      clock_ready_i = 1'b1;
      for (c = 1; c <= 10; c++)
      begin
         @(posedge lms_clk);
         @(negedge lms_clk);
         if (pll_rst_o) high_cycles++;
         check_value(32'(pll_rst_o), 32'(c <= 5), $sformatf("pll_rst cycle %0d", c));
      end
      check_value(32'(high_cycles), 5, "pll_rst pulse length");
      for (c = 0; c < 8; c++)
      begin
         drive = lms_pkg::led_t'($random(seed));
         leds_i = drive;
         @(posedge lms_clk);
         @(negedge lms_clk);
         check_value(32'(leds_o), 32'(drive ^ led_mask), $sformatf("leds step %0d", c));
      end
      report_test_end("raise_clock_ready", errs);
   endtask

   initial
   begin
      rx1_d_i = '0;
      rx2_d_i = '0;
      rx1_iqsel_i = 1'b0;
      rx2_iqsel_i = 1'b0;
      dac_i0_i = lms_pkg::lms_bus_t'($random(seed));  // Held through the release
      dac_q0_i = lms_pkg::lms_bus_t'($random(seed));
      dac_i1_i = lms_pkg::lms_bus_t'($random(seed));
      dac_q1_i = lms_pkg::lms_bus_t'($random(seed));
      {sclk_i, mosi_i, miso1_i, miso2_i} = 4'b0000;
      {sen_dac_i, sen_lms1_i, sen_lms2_i} = 3'b111;  // All devices idle
      clock_ready_i = 1'b0;
      leds_i = '0;
      after_reset_checks();
      capture_rx_words();
      interleave_tx_words();
      walk_spi_enables();
      raise_clock_ready();
      $display("Summary: %0d checks, %0d failed", checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   initial
   begin
      repeat (watchdog_cycles) @(posedge lms_clk);
      $display("Timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* sources.f */
rtl/lms_pkg.sv
rtl/lms_rx_capture.sv
rtl/lms_tx_interleave.sv
rtl/spi_fanout.sv
rtl/board_status.sv
rtl/lms_frontend_top.sv
verif/tb_clock_gen.sv
verif/tb_lms_frontend.sv

/* Makefile */
# Verilator build and run of the LMS frontend testbench

SIM = obj_dir/Vtb_lms_frontend

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): sources.f $(wildcard rtl/*.sv verif/*.sv)
	verilator --binary --timing --timescale 1ns/1ps -f sources.f --top-module tb_lms_frontend

# Pass or fail comes from the log
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
